//--- tests/cpu_testdata.txt
// word count, program words eight per line, expected record count,
// then writeback records as register and value pairs
002F
D112 D2F0 0152 F3A5 235A 13F0 33FF 930F
8304 83F8 04D3 0491 0412 0423 0431 D502
0485 D6FE 0486 55FF D760 4347 4807 4247
4907 B102 C001 DA11 C101 DA22 01B2 CA01
DB33 CD01 DB44 02B1 CA01 DB55 CD01 DC66
CE01 DC77 DD03 9D01 C1FE E000 DE99
001E
0001 0012  0002 FFF0  0001 0002  0003 A500  0003 A55A
0003 0050  0003 00AF  0003 00A0  0003 0A00  0003 000A
0004 000A  0004 0008  0004 0000  0004 000A  0004 0008
0005 0002  0004 0020  0006 FFFE  0004 0008  0005 0001
0007 0060  0008 000A  0009 FFF0  000A 0022  000B 0055
000C 0066  000D 0003  000D 0002  000D 0001  000D 0000

//--- cpu.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/ram.sv
verilog/cpuDatapath.sv
verilog/cpuFsm.sv
verilog/cpu.sv
tests/cpuTb.sv

//--- run.sh
#!/bin/bash
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
	--top-module cpuTb -f cpu.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VcpuTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

//--- tests/cpuTb.sv
`default_nettype none

module cpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALT_TIMEOUT = 2000;
	localparam int HOLD_CYCLES = 20;
	localparam int MAX_WORDS = 200;
	localparam int RESET_CYCLES = 10;

	logic Clk;
	logic rst;
	logic [15:0] RdestOut;
	logic wbStrobe;
	logic [3:0] wbAddr;
	logic [15:0] wbData;
	logic halted;

	// word count, program, record count, then register and value pairs
	logic [15:0] testData [256];
	int wordCount;
	int recordCount;
	int recordBase;
	int recordIdx;
	int errorCount;
	int checkCount;
	logic timedOut;

	cpu DUT (
		.Clk(Clk),
		.rst(rst),
		.RdestOut(RdestOut),
		.wbStrobe(wbStrobe),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.halted(halted)
	);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	function automatic logic [15:0] dataAt(input int pos);
		return testData[pos[7:0]];
	endfunction

	// last value the expected trace leaves in a register, zero after reset
	function automatic logic [15:0] finalRegValue(input logic [3:0] regNum);
		logic [15:0] value;
		value = '0;
		for (int r = 0; r < recordCount; r++) begin
			if (dataAt(recordBase + 2 * r) == {12'h000, regNum}) begin
				value = dataAt(recordBase + 2 * r + 1);
			end
		end
		return value;
	endfunction

	// Rdest field of the first HALT word in the program
	function automatic logic [3:0] haltDest();
		logic [3:0] dest;
		logic found;
		dest = '0;
		found = 1'b0;
		for (int i = 1; i <= wordCount; i++) begin
			if (!found && testData[i[7:0]][15:12] == 4'hE) begin
				dest = testData[i[7:0]][11:8];
				found = 1'b1;
			end
		end
		return dest;
	endfunction

	task automatic checkValue(input string sigName, input logic [15:0] expected,
			input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERR t=%0t %s expected %h actual %h", $time, sigName, expected, actual);
		end
	endtask

	// no writeback and no halt yet
	task automatic expectIdle();
		checkValue("wbStrobe", 16'h0000, {15'h0000, wbStrobe});
		checkValue("halted", 16'h0000, {15'h0000, halted});
	endtask

	task automatic loadProgram();
		$readmemh("tests/cpu_testdata.txt", testData);
		wordCount = int'(testData[0]);
		if (wordCount == 0 || wordCount > MAX_WORDS) begin
			errorCount++;
			$display("test data file holds no usable program (%0d words)", wordCount);
			wordCount = 0;
		end
		for (int i = 0; i < wordCount; i++) begin
			DUT.ramInst.memory[i[9:0]] = dataAt(i + 1);
		end
		recordCount = int'(dataAt(wordCount + 1));
		recordBase = wordCount + 2;
	endtask

	// writeback trace against the expected records, in order
	always @(negedge Clk) begin
		if (!rst && wbStrobe) begin
			if (recordIdx < recordCount) begin
				checkValue("wbAddr", dataAt(recordBase + 2 * recordIdx), {12'h000, wbAddr});
				checkValue("wbData", dataAt(recordBase + 2 * recordIdx + 1), wbData);
				recordIdx++;
			end else begin
				errorCount++;
				$display("unexpected writeback to r%0d at %0t, all %0d records already used",
					wbAddr, $time, recordCount);
			end
		end
	end

	initial begin
		logic [15:0] expRdest;
		int cycles;

		rst = 1'b1;
		errorCount = 0;
		checkCount = 0;
		recordIdx = 0;
		timedOut = 1'b0;
		loadProgram();

		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge Clk);
			#1;
			expectIdle();
		end
		rst = 1'b0;

		// still in the first FETCH
		@(negedge Clk);
		expectIdle();

		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge Clk);
			cycles++;
		end
		if (!halted) begin
			errorCount++;
			timedOut = 1'b1;
			$display("timeout: halted still low after %0d cycles", HALT_TIMEOUT);
		end

		// HALT keeps its own Rdest register on RdestOut
		if (!timedOut) begin
			expRdest = finalRegValue(haltDest());
			for (int c = 0; c < HOLD_CYCLES; c++) begin
				@(negedge Clk);
				checkValue("RdestOut", expRdest, RdestOut);
				checkValue("wbStrobe", 16'h0000, {15'h0000, wbStrobe});
				checkValue("halted", 16'h0001, {15'h0000, halted});
			end
		end

		if (recordIdx != recordCount) begin
			errorCount++;
			$display("writeback trace ended after %0d of %0d expected records",
				recordIdx, recordCount);
		end

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpu (
	input wire Clk,
	input wire rst,
	output logic [`CPU_DATA_W-1:0] RdestOut,
	output logic wbStrobe,
	output logic [3:0] wbAddr,
	output logic [`CPU_DATA_W-1:0] wbData,
	output logic halted
);

	logic [3:0] rdestLoc;
	logic [3:0] rsrcLoc;
	isaPkg::aluOpE aluOp;
	logic immSel;
	ctrlPkg::immModeE immMode;
	logic regEn;
	ctrlPkg::loadSelE loadSel;
	logic ramEn;
	ctrlPkg::addrSelE addrSel;
	logic [7:0] imm;
	logic [`CPU_ADDR_W-1:0] pcOut;
	logic [`CPU_ADDR_W-1:0] ramAddr;
	logic [`CPU_DATA_W-1:0] ramOut;
	logic [`CPU_DATA_W-1:0] rsrcOut;
	logic [`CPU_DATA_W-1:0] aluOut;
	logic [`CPU_DATA_W-1:0] loadOut;
	logic [4:0] flags;

	// writeback trace mirrors the register write port
	assign wbStrobe = regEn;
	assign wbAddr = rdestLoc;
	assign wbData = loadOut;

	cpuDatapath datapath (
		.Clk(Clk),
		.rst(rst),
		.regEn(regEn),
		.rdestLoc(rdestLoc),
		.rsrcLoc(rsrcLoc),
		.aluOp(aluOp),
		.immSel(immSel),
		.immMode(immMode),
		.imm(imm),
		.loadSel(loadSel),
		.addrSel(addrSel),
		.pcOut(pcOut),
		.ramOut(ramOut),
		.rdestOut(RdestOut),
		.rsrcOut(rsrcOut),
		.aluOut(aluOut),
		.flags(flags),
		.ramAddr(ramAddr),
		.loadOut(loadOut)
	);

	cpuFsm fsm (
		.Clk(Clk),
		.rst(rst),
		.instr(ramOut),
		.aluFlags(flags),
		.rdestLoc(rdestLoc),
		.rsrcLoc(rsrcLoc),
		.aluOp(aluOp),
		.immSel(immSel),
		.immMode(immMode),
		.regEn(regEn),
		.loadSel(loadSel),
		.ramEn(ramEn),
		.addrSel(addrSel),
		.imm(imm),
		.pcOut(pcOut),
		.halted(halted)
	);

	// store data always comes from Rdest
	ram ramInst (
		.Clk(Clk),
		.addr(ramAddr),
		.wrData(RdestOut),
		.we(ramEn),
		.rdData(ramOut)
	);

endmodule

`default_nettype wire

//--- verilog/cpuFsm.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpuFsm (
	input wire Clk,
	input wire rst,
	input wire [`CPU_DATA_W-1:0] instr,
	input wire [4:0] aluFlags,
	output logic [3:0] rdestLoc,
	output logic [3:0] rsrcLoc,
	output isaPkg::aluOpE aluOp,
	output logic immSel,
	output ctrlPkg::immModeE immMode,
	output logic regEn,
	output ctrlPkg::loadSelE loadSel,
	output logic ramEn,
	output ctrlPkg::addrSelE addrSel,
	output logic [7:0] imm,
	output logic [`CPU_ADDR_W-1:0] pcOut,
	output logic halted
);

	ctrlPkg::stateE state;
	ctrlPkg::stateE nextState;
	logic [isaPkg::INSTR_W-1:0] ir;
	logic [4:0] flagReg;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] disp;
	isaPkg::opcodeE irOp;
	isaPkg::opcodeE newOp;
	logic [3:0] irExt;
	logic isAluReg;
	logic isAluImm;
	logic isCmp;
	logic branchTaken;

	// fields of the latched instruction
	assign irOp = isaPkg::opcodeE'(ir[isaPkg::OP_MSB:isaPkg::OP_LSB]);
	assign irExt = ir[isaPkg::EXT_MSB:isaPkg::EXT_LSB];
	assign rdestLoc = ir[isaPkg::RDEST_MSB:isaPkg::RDEST_LSB];
	assign rsrcLoc = ir[isaPkg::RSRC_MSB:isaPkg::RSRC_LSB];
	assign imm = ir[isaPkg::IMM_MSB:isaPkg::IMM_LSB];

	// instruction word on the RAM output during DECODE
	assign newOp = isaPkg::opcodeE'(instr[isaPkg::OP_MSB:isaPkg::OP_LSB]);

	assign disp = {{(`CPU_ADDR_W - 8){imm[7]}}, imm};
	assign pcOut = pc;
	assign halted = (state == ctrlPkg::HALTED);

	always_comb begin
		isAluReg = (irOp == isaPkg::OP_RTYPE);
		case (irOp)
			isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_ADDI,
			isaPkg::OP_LSHI, isaPkg::OP_SUBI, isaPkg::OP_CMPI, isaPkg::OP_MOVI,
			isaPkg::OP_LUI: isAluImm = 1'b1;
			default: isAluImm = 1'b0;
		endcase
		// immediate opcodes carry the ALU op code directly
		aluOp = isAluReg ? isaPkg::aluOpE'(irExt) : isaPkg::aluOpE'(irOp);
		isCmp = (isAluReg || isAluImm) && (aluOp == isaPkg::ALU_CMP);
	end

	always_comb begin
		case (isaPkg::condE'(rdestLoc))
			isaPkg::COND_EQ: branchTaken = flagReg[isaPkg::FLAG_Z];
			isaPkg::COND_NE: branchTaken = !flagReg[isaPkg::FLAG_Z];
			isaPkg::COND_LO: branchTaken = flagReg[isaPkg::FLAG_L];
			isaPkg::COND_GE: branchTaken = !flagReg[isaPkg::FLAG_N];
			isaPkg::COND_UC: branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		nextState = state;
		regEn = 1'b0;
		ramEn = 1'b0;
		immSel = isAluImm;
		loadSel = ctrlPkg::LOAD_ALU;
		addrSel = ctrlPkg::ADDR_PC;
		case (irOp)
			isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI: immMode = ctrlPkg::IMM_ZERO;
			isaPkg::OP_LUI: immMode = ctrlPkg::IMM_UPPER;
			default: immMode = ctrlPkg::IMM_SIGN;
		endcase
		case (state)
			ctrlPkg::FETCH: nextState = ctrlPkg::DECODE;
			ctrlPkg::DECODE: begin
				case (newOp)
					isaPkg::OP_MEM: nextState = ctrlPkg::MEMADDR;
					isaPkg::OP_HALT: nextState = ctrlPkg::HALTED;
					// opcodes left unassigned in the 4-bit space
					4'h6, 4'h7, 4'hA: nextState = ctrlPkg::FETCH;
					default: nextState = ctrlPkg::EXECUTE;
				endcase
			end
			ctrlPkg::EXECUTE: begin
				if (isCmp || irOp == isaPkg::OP_BCOND) begin
					nextState = ctrlPkg::FETCH;
				end else begin
					nextState = ctrlPkg::WRITEBACK;
				end
			end
			ctrlPkg::MEMADDR: begin
				addrSel = ctrlPkg::ADDR_RSRC;
				if (irExt == isaPkg::MEM_STOR) begin
					ramEn = 1'b1;
					nextState = ctrlPkg::FETCH;
				end else if (irExt == isaPkg::MEM_LOAD) begin
					nextState = ctrlPkg::MEMWAIT;
				end else begin
					nextState = ctrlPkg::FETCH;
				end
			end
			ctrlPkg::MEMWAIT: begin
				addrSel = ctrlPkg::ADDR_RSRC;
				nextState = ctrlPkg::WRITEBACK;
			end
			ctrlPkg::WRITEBACK: begin
				regEn = 1'b1;
				// LOAD writes the word read during MEMWAIT
				if (irOp == isaPkg::OP_MEM) begin
					loadSel = ctrlPkg::LOAD_RAM;
				end
				nextState = ctrlPkg::FETCH;
			end
			ctrlPkg::HALTED: nextState = ctrlPkg::HALTED;
			default: nextState = ctrlPkg::FETCH;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= ctrlPkg::FETCH;
			pc <= '0;
			ir <= '0;
			flagReg <= '0;
		end else begin
			state <= nextState;
			if (state == ctrlPkg::DECODE) begin
				ir <= instr;
				pc <= pc + 1'b1;
			end
			if (state == ctrlPkg::EXECUTE) begin
				if (isAluReg || isAluImm) begin
					flagReg <= aluFlags;
				end else if (irOp == isaPkg::OP_BCOND && branchTaken) begin
					// pc already points past the branch
					pc <= pc + disp;
				end
			end
		end
	end

	noRegRamOverlap: assert property (@(posedge Clk) disable iff (rst)
		!(regEn && ramEn));

	haltSticky: assert property (@(posedge Clk) disable iff (rst)
		state == ctrlPkg::HALTED |=> state == ctrlPkg::HALTED);

endmodule

`default_nettype wire

//--- verilog/cpuDatapath.sv
`default_nettype none
`include "cpu_cfg.svh"

module cpuDatapath (
	input wire Clk,
	input wire rst,
	input wire regEn,
	input wire [3:0] rdestLoc,
	input wire [3:0] rsrcLoc,
	input wire isaPkg::aluOpE aluOp,
	input wire immSel,
	input wire ctrlPkg::immModeE immMode,
	input wire [7:0] imm,
	input wire ctrlPkg::loadSelE loadSel,
	input wire ctrlPkg::addrSelE addrSel,
	input wire [`CPU_ADDR_W-1:0] pcOut,
	input wire [`CPU_DATA_W-1:0] ramOut,
	output logic [`CPU_DATA_W-1:0] rdestOut,
	output logic [`CPU_DATA_W-1:0] rsrcOut,
	output logic [`CPU_DATA_W-1:0] aluOut,
	output logic [4:0] flags,
	output logic [`CPU_ADDR_W-1:0] ramAddr,
	output logic [`CPU_DATA_W-1:0] loadOut
);

	logic [`CPU_DATA_W-1:0] immExt;
	logic [`CPU_DATA_W-1:0] aluB;

	// LUI moves the byte up inside the ALU
	always_comb begin
		case (immMode)
			ctrlPkg::IMM_SIGN: immExt = {{8{imm[7]}}, imm};
			ctrlPkg::IMM_ZERO, ctrlPkg::IMM_UPPER: immExt = {8'h00, imm};
			default: immExt = {8'h00, imm};
		endcase
	end

	assign aluB = immSel ? immExt : rsrcOut;
	assign loadOut = (loadSel == ctrlPkg::LOAD_RAM) ? ramOut : aluOut;
	assign ramAddr = (addrSel == ctrlPkg::ADDR_RSRC) ? rsrcOut[`CPU_ADDR_W-1:0] : pcOut;

	regFile regs (
		.Clk(Clk),
		.rst(rst),
		.en(regEn),
		.rdestLoc(rdestLoc),
		.rsrcLoc(rsrcLoc),
		.load(loadOut),
		.rdestOut(rdestOut),
		.rsrcOut(rsrcOut)
	);

	alu aluInst (
		.a(rdestOut),
		.b(aluB),
		.op(aluOp),
		.out(aluOut),
		.flags(flags)
	);

endmodule

`default_nettype wire

//--- verilog/ram.sv
`default_nettype none
`include "cpu_cfg.svh"

module ram (
	input wire Clk,
	input wire [`CPU_ADDR_W-1:0] addr,
	input wire [`CPU_DATA_W-1:0] wrData,
	input wire we,
	output logic [`CPU_DATA_W-1:0] rdData
);

	logic [`CPU_DATA_W-1:0] memory [`CPU_MEM_DEPTH];

	// read returns the old word when written in the same cycle
	always_ff @(posedge Clk) begin
		if (we) begin
			memory[addr] <= wrData;
		end
		rdData <= memory[addr];
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none
`include "cpu_cfg.svh"

module alu (
	input wire [`CPU_DATA_W-1:0] a,
	input wire [`CPU_DATA_W-1:0] b,
	input wire isaPkg::aluOpE op,
	output logic [`CPU_DATA_W-1:0] out,
	output logic [4:0] flags
);

	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	logic [`CPU_DATA_W-1:0] negB;
	logic carry;
	logic ovf;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};
	assign negB = -b;

	always_comb begin
		out = '0;
		carry = 1'b0;
		ovf = 1'b0;
		case (op)
			isaPkg::ALU_ADD: begin
				out = sum[`CPU_DATA_W-1:0];
				carry = sum[`CPU_DATA_W];
				ovf = (a[15] == b[15]) && (out[15] != a[15]);
			end
			// CMP is a SUB whose result is dropped
			isaPkg::ALU_SUB, isaPkg::ALU_CMP: begin
				out = diff[`CPU_DATA_W-1:0];
				carry = diff[`CPU_DATA_W];
				ovf = (a[15] != b[15]) && (out[15] != a[15]);
			end
			isaPkg::ALU_AND: out = a & b;
			isaPkg::ALU_OR: out = a | b;
			isaPkg::ALU_XOR: out = a ^ b;
			isaPkg::ALU_MOV: out = b;
			// negative amount shifts right
			isaPkg::ALU_LSH: begin
				if (b[15]) begin
					out = a >> negB;
				end else begin
					out = a << b;
				end
			end
			isaPkg::ALU_LUI: out = {b[7:0], 8'h00};
			default: out = '0;
		endcase
	end

	// L and N compare Rdest below the source operand
	always_comb begin
		flags = '0;
		flags[isaPkg::FLAG_C] = carry;
		flags[isaPkg::FLAG_L] = a < b;
		flags[isaPkg::FLAG_F] = ovf;
		flags[isaPkg::FLAG_Z] = (out == '0);
		flags[isaPkg::FLAG_N] = $signed(a) < $signed(b);
	end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none
`include "cpu_cfg.svh"

module regFile (
	input wire Clk,
	input wire rst,
	input wire en,
	input wire [3:0] rdestLoc,
	input wire [3:0] rsrcLoc,
	input wire [`CPU_DATA_W-1:0] load,
	output logic [`CPU_DATA_W-1:0] rdestOut,
	output logic [`CPU_DATA_W-1:0] rsrcOut
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (en) begin
			regs[rdestLoc] <= load;
		end
	end

	// both read ports are asynchronous
	assign rdestOut = regs[rdestLoc];
	assign rsrcOut = regs[rsrcLoc];

	// write index comes from the FSM instruction register
	wrAddrKnown: assert property (@(posedge Clk) disable iff (rst)
		en |-> !$isunknown(rdestLoc));

endmodule

`default_nettype wire

//--- verilog/ctrlPkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package ctrlPkg;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMADDR,
		MEMWAIT,
		WRITEBACK,
		HALTED
	} stateE;

	// register write source
	typedef enum logic {
		LOAD_ALU,
		LOAD_RAM
	} loadSelE;

	// RAM address source
	typedef enum logic {
		ADDR_PC,
		ADDR_RSRC
	} addrSelE;

	typedef enum logic [1:0] {
		IMM_SIGN,
		IMM_ZERO,
		IMM_UPPER
	} immModeE;

endpackage

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package isaPkg;

	localparam int INSTR_W = `CPU_DATA_W;

	// instruction field positions
	localparam int OP_MSB = 15;
	localparam int OP_LSB = 12;
	localparam int RDEST_MSB = 11;
	localparam int RDEST_LSB = 8;
	localparam int EXT_MSB = 7;
	localparam int EXT_LSB = 4;
	localparam int RSRC_MSB = 3;
	localparam int RSRC_LSB = 0;
	localparam int IMM_MSB = 7;
	localparam int IMM_LSB = 0;

	// immediate opcodes share their code with the matching ALU op
	typedef enum logic [3:0] {
		OP_RTYPE = 4'h0,
		OP_ANDI = 4'h1,
		OP_ORI = 4'h2,
		OP_XORI = 4'h3,
		OP_MEM = 4'h4,
		OP_ADDI = 4'h5,
		OP_LSHI = 4'h8,
		OP_SUBI = 4'h9,
		OP_CMPI = 4'hB,
		OP_BCOND = 4'hC,
		OP_MOVI = 4'hD,
		OP_HALT = 4'hE,
		OP_LUI = 4'hF
	} opcodeE;

	// extended field of register forms
	typedef enum logic [3:0] {
		ALU_AND = 4'h1,
		ALU_OR = 4'h2,
		ALU_XOR = 4'h3,
		ALU_ADD = 4'h5,
		ALU_LSH = 4'h8,
		ALU_SUB = 4'h9,
		ALU_CMP = 4'hB,
		ALU_MOV = 4'hD,
		ALU_LUI = 4'hF
	} aluOpE;

	// extended field under OP_MEM
	typedef enum logic [3:0] {
		MEM_LOAD = 4'h0,
		MEM_STOR = 4'h4
	} memOpE;

	// branch condition sits in the Rdest field
	typedef enum logic [3:0] {
		COND_EQ = 4'h0,
		COND_NE = 4'h1,
		COND_LO = 4'hA,
		COND_GE = 4'hD,
		COND_UC = 4'hE
	} condE;

	typedef enum logic [2:0] {
		FLAG_C = 3'd0,
		FLAG_L = 3'd1,
		FLAG_F = 3'd2,
		FLAG_Z = 3'd3,
		FLAG_N = 3'd4
	} flagIdxE;

endpackage

`default_nettype wire

//--- verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath word and register file width
`define CPU_DATA_W 16

// one word addressed RAM shared by program and data
`define CPU_ADDR_W 10
`define CPU_MEM_DEPTH 1024

// Rdest and Rsrc fields are 4 bits wide
`define CPU_REG_COUNT 16

`endif
